/* common/matrix_pkg.sv */
// matrix terminal package with the shared widths, limits, timing counts, ascii and mode codes
package matrix_pkg;

	// ====================
	// widths and limits
	// ====================
	localparam int elem_w     = 8;                  // one stored element
	localparam int dim_w      = 3;                  // row or column count
	localparam int max_dim    = 5;                  // largest m or n
	localparam int mat_elems  = 25;                 // max_dim * max_dim positions
	localparam int mat_flat_w = mat_elems * elem_w; // element k at byte k in row-major order
	localparam int idx_w      = $clog2(mat_elems);  // element index / count
	localparam int slots      = 2;                  // store depth
	localparam int slot_w     = 1;                  // slot index

	// ====================
	// timing counts
	// ====================
	// all counts are in clock cycles
	localparam int clks_per_bit    = 16;
	localparam int baud_cnt_w      = $clog2(clks_per_bit);
	localparam int debounce_cycles = 8;             // stable cycles before a level counts
	localparam int deb_cnt_w       = $clog2(debounce_cycles);
	localparam int led_hold_cycles = 64;            // status flash length
	localparam int led_cnt_w       = $clog2(led_hold_cycles);

	// ====================
	// ascii codes
	// ====================
	localparam logic [elem_w-1:0] asc_zero  = 8'h30; // "0"
	localparam logic [elem_w-1:0] asc_nine  = 8'h39; // "9"
	localparam logic [elem_w-1:0] asc_cr    = 8'h0d;
	localparam logic [elem_w-1:0] asc_lf    = 8'h0a;
	localparam logic [elem_w-1:0] asc_space = 8'h20;
	localparam logic [elem_w-1:0] asc_err   = 8'h45; // "E" marks an empty slot

	// mode codes take the values of command[2:0]
	localparam logic [2:0] mode_idle    = 3'd0;
	localparam logic [2:0] mode_input   = 3'd1;
	localparam logic [2:0] mode_display = 3'd2;

endpackage

/* src/btn_debouncer.sv */
// button debouncer, one press pulse per clean rising edge of the button level
module btn_debouncer (
	input  logic clk,
	input  logic rst_n,
	input  logic btn,
	output logic press
);

	logic [1:0] btn_sync;                            // metastability guard
	logic       btn_clean;                           // accepted level
	logic [matrix_pkg::deb_cnt_w-1:0] stable_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_sync   <= 2'b00;
			btn_clean  <= 1'b0;
			stable_cnt <= '0;
			press      <= 1'b0;
		end else begin
			btn_sync <= {btn_sync[0], btn};
			press    <= 1'b0;
			if (btn_sync[1] == btn_clean) begin
				stable_cnt <= '0;                // bounce, start over
			end else if (stable_cnt == matrix_pkg::deb_cnt_w'(matrix_pkg::debounce_cycles - 1)) begin
				btn_clean  <= btn_sync[1];
				stable_cnt <= '0;
				press      <= btn_sync[1];       // rising edge only
			end else begin
				stable_cnt <= stable_cnt + 1'b1;
			end
		end
	end

endmodule

/* uart/uart_rx.sv */
// uart receiver, 8N1, every bit sampled at its middle by the bit timer
module uart_rx (
	input  logic clk,
	input  logic rst_n,
	input  logic rxd,
	output logic [matrix_pkg::elem_w-1:0] rx_data,
	output logic rx_done
);

	localparam logic [1:0] st_idle  = 2'd0;
	localparam logic [1:0] st_start = 2'd1;
	localparam logic [1:0] st_data  = 2'd2;
	localparam logic [1:0] st_stop  = 2'd3;

	localparam int half_bit = matrix_pkg::clks_per_bit / 2;

	logic [1:0] state;
	logic [1:0] rxd_sync;                            // line idles high
	logic [matrix_pkg::baud_cnt_w-1:0] bit_cnt;      // clocks inside a bit
	logic [2:0] bit_idx;                             // data bit number
	logic [matrix_pkg::elem_w-1:0] shift_q;

	wire rx_line  = rxd_sync[1];
	wire full_bit = (bit_cnt == matrix_pkg::baud_cnt_w'(matrix_pkg::clks_per_bit - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= st_idle;
			rxd_sync <= 2'b11;
			bit_cnt  <= '0;
			bit_idx  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rx_done  <= 1'b0;
			bit_cnt  <= bit_cnt + 1'b1;
			case (state)
				st_idle: begin
					bit_cnt <= '0;
					if (!rx_line)
						state <= st_start;       // falling edge, maybe a start bit
				end
				st_start: if (bit_cnt == matrix_pkg::baud_cnt_w'(half_bit - 1)) begin
					bit_cnt <= '0;
					bit_idx <= '0;
					state   <= rx_line ? st_idle : st_data; // glitch goes back to idle
				end
				st_data: if (full_bit) begin
					bit_cnt <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7)
						state <= st_stop;
				end
				default: if (full_bit) begin     // middle of the stop bit
					rx_done <= 1'b1;
					state   <= st_idle;
				end
			endcase
		end
	end

	// data path, lsb first
	always_ff @(posedge clk) begin
		if (state == st_data && full_bit)
			shift_q <= {rx_line, shift_q[matrix_pkg::elem_w-1:1]};
		if (state == st_stop && full_bit)
			rx_data <= shift_q;                  // held until the next frame ends
	end

endmodule

/* uart/uart_tx.sv */
// uart transmitter for 8N1 frames with busy from the cycle after tx_en to the end of the stop bit
module uart_tx (
	input  logic clk,
	input  logic rst_n,
	input  logic tx_en,
	input  logic [matrix_pkg::elem_w-1:0] tx_data,
	output logic txd,
	output logic tx_busy
);

	logic [9:1] frame;                               // stop and data after the start bit
	logic [3:0] bit_idx;                             // 0 start .. 9 stop
	logic [matrix_pkg::baud_cnt_w-1:0] bit_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			txd     <= 1'b1;                     // idle line
			tx_busy <= 1'b0;
			bit_idx <= '0;
			bit_cnt <= '0;
		end else if (!tx_busy) begin
			if (tx_en) begin
				tx_busy <= 1'b1;
				txd     <= 1'b0;             // start bit right away
				bit_idx <= '0;
				bit_cnt <= '0;
			end
		end else if (bit_cnt == matrix_pkg::baud_cnt_w'(matrix_pkg::clks_per_bit - 1)) begin
			bit_cnt <= '0;
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0;             // stop bit done and txd stays high
			end else begin
				bit_idx <= bit_idx + 1'b1;
				txd     <= frame[bit_idx + 4'd1];
			end
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// frame load only when idle so tx_en is ignored during a frame
	always_ff @(posedge clk) begin
		if (tx_en && !tx_busy)
			frame <= {1'b1, tx_data};
	end

endmodule

/* src/mode_controller.sv */
// mode controller, latches the command on confirm and drops back to idle on exit
module mode_controller (
	input  logic clk,
	input  logic rst_n,
	input  logic [2:0] command,
	input  logic confirm_press,
	input  logic exit_press,
	output logic input_mode,
	output logic display_mode
);

	logic [2:0] mode_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode_q <= matrix_pkg::mode_idle;
		end else if (exit_press) begin
			mode_q <= matrix_pkg::mode_idle;     // exit beats confirm
		end else if (confirm_press) begin
			if (command == matrix_pkg::mode_input || command == matrix_pkg::mode_display)
				mode_q <= command;
			else
				mode_q <= matrix_pkg::mode_idle; // unknown codes park in idle
		end
	end

	// one-hot by construction
	assign input_mode   = (mode_q == matrix_pkg::mode_input);
	assign display_mode = (mode_q == matrix_pkg::mode_display);

endmodule

/* matrix/matrix_parser.sv */
// matrix parser, turns the ascii digit stream into m, n and a flat element vector
module matrix_parser (
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	input  logic [matrix_pkg::elem_w-1:0] rx_data,
	input  logic rx_done,
	output logic [matrix_pkg::dim_w-1:0] parsed_m,
	output logic [matrix_pkg::dim_w-1:0] parsed_n,
	output logic [matrix_pkg::mat_flat_w-1:0] parsed_flat,
	output logic parse_done,
	output logic parse_error
);

	localparam logic [1:0] st_rows  = 2'd0;
	localparam logic [1:0] st_cols  = 2'd1;
	localparam logic [1:0] st_elems = 2'd2;

	logic [1:0] state;
	logic [matrix_pkg::idx_w-1:0] elem_cnt;          // next element position
	logic [matrix_pkg::idx_w-1:0] elem_total;        // m * n

	wire is_digit = (rx_data >= matrix_pkg::asc_zero) && (rx_data <= matrix_pkg::asc_nine);
	wire [matrix_pkg::elem_w-1:0] digit = rx_data - matrix_pkg::asc_zero;
	wire dim_ok = (digit >= 8'd1) && (digit <= 8'(matrix_pkg::max_dim));
	wire take   = enable && rx_done && is_digit;     // separators fall through here

	assign elem_total = matrix_pkg::idx_w'(parsed_m) * matrix_pkg::idx_w'(parsed_n);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= st_rows;
			elem_cnt    <= '0;
			parse_done  <= 1'b0;
			parse_error <= 1'b0;
		end else begin
			parse_done  <= 1'b0;
			parse_error <= 1'b0;
			if (!enable) begin
				state <= st_rows;                // leaving input mode restarts
			end else if (take) begin
				case (state)
					st_rows: begin
						if (dim_ok)
							state <= st_cols;
						else
							parse_error <= 1'b1;
					end
					st_cols: begin
						elem_cnt <= '0;
						if (dim_ok) begin
							state <= st_elems;
						end else begin
							parse_error <= 1'b1;
							state       <= st_rows;
						end
					end
					default: begin
						elem_cnt <= elem_cnt + 1'b1;
						if (elem_cnt == elem_total - 1'b1) begin
							parse_done <= 1'b1;  // flat is complete this cycle
							state      <= st_rows;
						end
					end
				endcase
			end
		end
	end

	// ====================
	// matrix payload
	// ====================
	always_ff @(posedge clk) begin
		if (take) begin
			case (state)
				st_rows: parsed_m <= digit[matrix_pkg::dim_w-1:0];
				st_cols: begin
					parsed_n    <= digit[matrix_pkg::dim_w-1:0];
					parsed_flat <= '0;           // unused positions read as zero
				end
				default: parsed_flat[elem_cnt*matrix_pkg::elem_w +: matrix_pkg::elem_w] <= digit;
			endcase
		end
	end

endmodule

/* matrix/matrix_store.sv */
// matrix store, two round-robin slots and one presented read register set
module matrix_store (
	input  logic clk,
	input  logic rst_n,
	input  logic write_en,
	input  logic [matrix_pkg::dim_w-1:0] wr_m,
	input  logic [matrix_pkg::dim_w-1:0] wr_n,
	input  logic [matrix_pkg::mat_flat_w-1:0] wr_flat,
	input  logic read_en,
	input  logic [matrix_pkg::slot_w-1:0] rd_index,
	output logic [matrix_pkg::dim_w-1:0] pres_m,
	output logic [matrix_pkg::dim_w-1:0] pres_n,
	output logic [matrix_pkg::mat_flat_w-1:0] pres_flat,
	output logic pres_ready
);

	logic [matrix_pkg::dim_w-1:0]      slot_m    [matrix_pkg::slots];
	logic [matrix_pkg::dim_w-1:0]      slot_n    [matrix_pkg::slots];
	logic [matrix_pkg::mat_flat_w-1:0] slot_flat [matrix_pkg::slots];
	logic [matrix_pkg::slots-1:0]      filled;      // slot written at least once
	logic [matrix_pkg::slot_w-1:0]     wr_ptr;      // next slot to overwrite

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			filled     <= '0;
			wr_ptr     <= '0;
			pres_ready <= 1'b0;
		end else begin
			pres_ready <= write_en || read_en;
			if (write_en) begin
				filled[wr_ptr] <= 1'b1;
				if (wr_ptr == matrix_pkg::slot_w'(matrix_pkg::slots - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	// slots and presented copy, a write wins over a read
	always_ff @(posedge clk) begin
		if (write_en) begin
			slot_m[wr_ptr]    <= wr_m;
			slot_n[wr_ptr]    <= wr_n;
			slot_flat[wr_ptr] <= wr_flat;
			pres_m            <= wr_m;           // echo the fresh matrix
			pres_n            <= wr_n;
			pres_flat         <= wr_flat;
		end else if (read_en) begin
			pres_m    <= filled[rd_index] ? slot_m[rd_index] : '0; // zero dims = empty
			pres_n    <= filled[rd_index] ? slot_n[rd_index] : '0;
			pres_flat <= slot_flat[rd_index];
		end
	end

endmodule

/* matrix/matrix_printer.sv */
// matrix printer, sends the presented matrix as uart text one byte at a time
module matrix_printer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic [matrix_pkg::dim_w-1:0] mat_m,
	input  logic [matrix_pkg::dim_w-1:0] mat_n,
	input  logic [matrix_pkg::mat_flat_w-1:0] mat_flat,
	input  logic tx_busy,
	output logic tx_en,
	output logic [matrix_pkg::elem_w-1:0] tx_data
);

	// handshake states
	localparam logic [1:0] st_idle = 2'd0;
	localparam logic [1:0] st_send = 2'd1;          // wait for a free transmitter
	localparam logic [1:0] st_rise = 2'd2;          // wait for busy to rise
	localparam logic [1:0] st_fall = 2'd3;          // wait for busy to fall

	// byte kinds
	localparam logic [2:0] k_digit = 3'd0;
	localparam logic [2:0] k_space = 3'd1;
	localparam logic [2:0] k_cr    = 3'd2;
	localparam logic [2:0] k_lf    = 3'd3;
	localparam logic [2:0] k_err   = 3'd4;

	logic [1:0] state;
	logic [2:0] kind;
	logic       last;                                // final lf is on the wire
	logic [matrix_pkg::dim_w-1:0] row, col;
	logic [matrix_pkg::dim_w-1:0] m_q, n_q;
	logic [matrix_pkg::mat_flat_w-1:0] flat_q;
	logic [matrix_pkg::idx_w-1:0] elem_idx;
	logic [matrix_pkg::elem_w-1:0] next_byte;

	wire empty = (m_q == '0) || (n_q == '0);

	assign elem_idx = matrix_pkg::idx_w'(row) * matrix_pkg::idx_w'(n_q) + matrix_pkg::idx_w'(col);

	always_comb begin
		case (kind)
			k_digit: next_byte = flat_q[elem_idx*matrix_pkg::elem_w +: matrix_pkg::elem_w]
				+ matrix_pkg::asc_zero;
			k_space: next_byte = matrix_pkg::asc_space;
			k_cr:    next_byte = matrix_pkg::asc_cr;
			k_lf:    next_byte = matrix_pkg::asc_lf;
			default: next_byte = matrix_pkg::asc_err;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
			kind  <= k_digit;
			last  <= 1'b0;
			row   <= '0;
			col   <= '0;
			tx_en <= 1'b0;
		end else begin
			tx_en <= 1'b0;
			case (state)
				st_idle: if (start) begin        // start while busy is dropped
					row   <= '0;
					col   <= '0;
					last  <= 1'b0;
					kind  <= (mat_m == '0 || mat_n == '0) ? k_err : k_digit;
					state <= st_send;
				end
				st_send: if (!tx_busy) begin
					tx_en <= 1'b1;
					state <= st_rise;
					case (kind)              // pick the byte after this one
						k_digit: begin
							if (col == n_q - 1'b1) begin
								col  <= '0;
								kind <= k_cr;    // row done
							end else begin
								col  <= col + 1'b1;
								kind <= k_space;
							end
						end
						k_space: kind <= k_digit;
						k_cr:    kind <= k_lf;
						k_lf: begin
							if (empty || row == m_q - 1'b1) begin
								last <= 1'b1;
							end else begin
								row  <= row + 1'b1;
								kind <= k_digit;
							end
						end
						default: kind <= k_cr;   // "E" then cr lf
					endcase
				end
				st_rise: if (tx_busy) state <= st_fall;
				default: if (!tx_busy) state <= last ? st_idle : st_send;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == st_idle && start) begin
			m_q    <= mat_m;
			n_q    <= mat_n;
			flat_q <= mat_flat;
		end
		if (state == st_send && !tx_busy)
			tx_data <= next_byte;
	end

endmodule

/* src/sys_top.sv */
// matrix terminal top, uart text input and display of a two-slot matrix store
module sys_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [7:0] command,                      // only [2:0] carries a mode
	input  logic btn_confirm,
	input  logic btn_exit,
	input  logic uart_rxd,
	output logic uart_txd,
	output logic [7:0] led,
	output logic [7:0] ld2
);

	logic confirm_press, exit_press;
	logic input_mode, display_mode;
	logic [matrix_pkg::elem_w-1:0] rx_data, tx_data;
	logic rx_done, tx_en, tx_busy;
	logic [matrix_pkg::dim_w-1:0] parsed_m, parsed_n, pres_m, pres_n;
	logic [matrix_pkg::mat_flat_w-1:0] parsed_flat, pres_flat;
	logic parse_done, parse_error, pres_ready;
	logic read_en;
	logic [matrix_pkg::slot_w-1:0] rd_index;
	logic [1:0] flash_trig, flash_on;                // [0] store write, [1] parse error

	// ====================
	// front end
	// ====================
	btn_debouncer u_db_confirm (.clk(clk), .rst_n(rst_n), .btn(btn_confirm), .press(confirm_press));
	btn_debouncer u_db_exit    (.clk(clk), .rst_n(rst_n), .btn(btn_exit),    .press(exit_press));

	mode_controller u_mode (
		.clk(clk), .rst_n(rst_n), .command(command[2:0]),
		.confirm_press(confirm_press), .exit_press(exit_press),
		.input_mode(input_mode), .display_mode(display_mode)
	);

	uart_rx u_rx (.clk(clk), .rst_n(rst_n), .rxd(uart_rxd), .rx_data(rx_data), .rx_done(rx_done));

	uart_tx u_tx (
		.clk(clk), .rst_n(rst_n), .tx_en(tx_en), .tx_data(tx_data),
		.txd(uart_txd), .tx_busy(tx_busy)
	);

	// ====================
	// matrix path
	// ====================
	matrix_parser u_parser (
		.clk(clk), .rst_n(rst_n), .enable(input_mode),
		.rx_data(rx_data), .rx_done(rx_done),
		.parsed_m(parsed_m), .parsed_n(parsed_n), .parsed_flat(parsed_flat),
		.parse_done(parse_done), .parse_error(parse_error)
	);

	// display mode, "0" or "1" asks for that slot
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			read_en  <= 1'b0;
			rd_index <= '0;
		end else begin
			read_en  <= display_mode && rx_done
				&& (rx_data == matrix_pkg::asc_zero || rx_data == matrix_pkg::asc_zero + 8'd1);
			rd_index <= matrix_pkg::slot_w'(rx_data - matrix_pkg::asc_zero);
		end
	end

	matrix_store u_store (
		.clk(clk), .rst_n(rst_n),
		.write_en(parse_done), .wr_m(parsed_m), .wr_n(parsed_n), .wr_flat(parsed_flat),
		.read_en(read_en), .rd_index(rd_index),
		.pres_m(pres_m), .pres_n(pres_n), .pres_flat(pres_flat), .pres_ready(pres_ready)
	);

	matrix_printer u_printer (
		.clk(clk), .rst_n(rst_n), .start(pres_ready),
		.mat_m(pres_m), .mat_n(pres_n), .mat_flat(pres_flat),
		.tx_busy(tx_busy), .tx_en(tx_en), .tx_data(tx_data)
	);

	// ====================
	// status leds
	// ====================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			led <= 8'd0;
		else
			led <= {6'd0, display_mode, input_mode};
	end

	assign flash_trig = {parse_error, parse_done};

	// one stretch counter per flash, a new event restarts it
	for (genvar i = 0; i < 2; i++) begin : g_flash
		logic [matrix_pkg::led_cnt_w-1:0] hold_cnt;
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				flash_on[i] <= 1'b0;
				hold_cnt    <= '0;
			end else if (flash_trig[i]) begin
				flash_on[i] <= 1'b1;
				hold_cnt    <= '0;
			end else if (flash_on[i]) begin
				if (hold_cnt == matrix_pkg::led_cnt_w'(matrix_pkg::led_hold_cycles - 1))
					flash_on[i] <= 1'b0;
				else
					hold_cnt <= hold_cnt + 1'b1;
			end
		end
	end

	assign ld2 = {6'd0, flash_on};

endmodule

/* verification/tb_sys_top.sv */
// random self-checking testbench for the matrix terminal with a uart driver, a uart monitor and a text model
module tb_sys_top;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int bit_cycles   = matrix_pkg::clks_per_bit;
	localparam int frame_cycles = 10 * bit_cycles;
	localparam int deb_hold     = 2 * matrix_pkg::debounce_cycles;
	localparam int n_echo       = 8;
	localparam int max_sent     = 3 * (2 + matrix_pkg::mat_elems); // digits plus separators
	localparam int max_text     = matrix_pkg::max_dim * (2 * matrix_pkg::max_dim + 1); // 5x5 echo
	// bytes per test as sent plus received plus one quiet frame per answer
	localparam longint total_bytes = 4 + (2 + 6 + 2) + n_echo * (max_sent + max_text + 1)
		+ (2 + 1 + max_sent + max_text + 1) + (2 + 2 * max_text + 2) + (4 + 1);
	localparam longint watchdog_ns = total_bytes * 10 * bit_cycles * 100 * 4;

	logic clk;
	logic rst_n;
	logic [7:0] command;
	logic btn_confirm;
	logic btn_exit;
	logic uart_rxd;
	logic uart_txd;
	logic [7:0] led;
	logic [7:0] ld2;

	logic [7:0] rx_q [$];                            // bytes seen on uart_txd
	logic [7:0] exp_q [$];                           // model text
	int tx_starts;                                   // start bits seen
	int starts_mark;
	int errors, tests, failed_tests, test_err;
	string cur_test;
	int elems [matrix_pkg::mat_elems];               // matrix being built in row-major order
	int slot_m [matrix_pkg::slots];
	int slot_n [matrix_pkg::slots];
	int slot_e [matrix_pkg::slots][matrix_pkg::mat_elems];
	int wr_slot;                                     // model of the round-robin pointer

	sys_top dut (
		.clk(clk), .rst_n(rst_n), .command(command),
		.btn_confirm(btn_confirm), .btn_exit(btn_exit),
		.uart_rxd(uart_rxd), .uart_txd(uart_txd), .led(led), .ld2(ld2)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ====================
	// uart monitor
	// ====================
	initial begin : uart_monitor
		logic [7:0] b;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge uart_txd);
			tx_starts++;
			repeat (bit_cycles / 2) @(negedge clk);          // middle of start bit
			for (int i = 0; i < 8; i++) begin
				repeat (bit_cycles) @(negedge clk);
				b[i] = uart_txd;                          // lsb first
			end
			repeat (bit_cycles) @(negedge clk);
			if (uart_txd !== 1'b1) begin
				errors++;
				test_err++;
				$display("ERROR %s: stop bit on uart_txd is not high", cur_test);
			end
			rx_q.push_back(b);
		end
	end

	// watchdog bound from the byte budget of all tests
	initial begin
		#(watchdog_ns);
		$display("timeout: the tests did not finish within %0d ns", watchdog_ns);
		$display("Simulation failed");
		$finish;
	end

	// ====================
	// helpers
	// ====================
	function automatic int rand_range(input int lo, input int hi);
		return lo + int'($urandom % 32'(hi - lo + 1));
	endfunction

	task automatic report_value(input string what, input logic [7:0] expected,
		input logic [7:0] actual);
		errors++;
		test_err++;
		$display("CHECK FAILED %s %s: expected %h actual %h", cur_test, what, expected, actual);
	endtask

	task automatic report_problem(input string msg);
		errors++;
		test_err++;
		$display("ERROR %s: %s", cur_test, msg);
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err = 0;
	endtask

	task automatic end_test();
		tests++;
		if (test_err != 0)
			failed_tests++;
		$display("test %s: %s, %0d errors", cur_test, test_err == 0 ? "ok" : "FAILED", test_err);
	endtask

	// one 8N1 frame on uart_rxd with bits changing on the falling edge
	task automatic send_byte(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0};
		@(negedge clk);
		for (int i = 0; i < 10; i++) begin
			uart_rxd = frame[i];
			repeat (bit_cycles) @(negedge clk);
		end
	endtask

	task automatic press(input bit use_exit);
		@(negedge clk);
		if (use_exit)
			btn_exit = 1'b1;
		else
			btn_confirm = 1'b1;
		repeat (deb_hold) @(negedge clk);               // well past the debounce count
		btn_exit    = 1'b0;
		btn_confirm = 1'b0;
		repeat (deb_hold) @(negedge clk);               // release settles too
	endtask

	task automatic enter_mode(input int code);
		command = 8'(code);
		press(1'b0);
	endtask

	// expected text from m, n and elems
	task automatic model_text(input int m, input int n);
		exp_q.delete();
		if (m == 0 || n == 0) begin
			exp_q.push_back(matrix_pkg::asc_err);   // empty slot
		end else begin
			for (int r = 0; r < m; r++) begin
				for (int c = 0; c < n; c++) begin
					exp_q.push_back(matrix_pkg::asc_zero + 8'(elems[r * n + c]));
					if (c != n - 1)
						exp_q.push_back(matrix_pkg::asc_space);
				end
				if (r != m - 1) begin
					exp_q.push_back(matrix_pkg::asc_cr);
					exp_q.push_back(matrix_pkg::asc_lf);
				end
			end
		end
		exp_q.push_back(matrix_pkg::asc_cr);            // every print ends in cr lf
		exp_q.push_back(matrix_pkg::asc_lf);
	endtask

	task automatic make_matrix(output int m, output int n);
		m = rand_range(1, matrix_pkg::max_dim);
		n = rand_range(1, matrix_pkg::max_dim);
		for (int k = 0; k < matrix_pkg::mat_elems; k++)
			elems[k] = (k < m * n) ? rand_range(0, 9) : 0;
	endtask

	task automatic send_separators();
		int cnt;
		cnt = rand_range(0, 2);
		for (int i = 0; i < cnt; i++) begin
			case (rand_range(0, 2))
				0: send_byte(matrix_pkg::asc_space);
				1: send_byte(matrix_pkg::asc_cr);
				default: send_byte(matrix_pkg::asc_lf);
			endcase
		end
	endtask

	// dims then elements with noise only before each digit
	task automatic send_matrix(input int m, input int n);
		send_separators();
		send_byte(matrix_pkg::asc_zero + 8'(m));
		send_separators();
		send_byte(matrix_pkg::asc_zero + 8'(n));
		for (int k = 0; k < m * n; k++) begin
			send_separators();
			send_byte(matrix_pkg::asc_zero + 8'(elems[k]));
		end
	endtask

	task automatic store_model(input int m, input int n);
		slot_m[wr_slot] = m;
		slot_n[wr_slot] = n;
		for (int k = 0; k < matrix_pkg::mat_elems; k++)
			slot_e[wr_slot][k] = elems[k];
		wr_slot = (wr_slot + 1) % matrix_pkg::slots;
	endtask

	task automatic slot_text(input int s);
		for (int k = 0; k < matrix_pkg::mat_elems; k++)
			elems[k] = slot_e[s][k];
		model_text(slot_m[s], slot_n[s]);
	endtask

	task automatic start_capture();
		rx_q.delete();
		starts_mark = tx_starts;
	endtask

	// wait for the full answer and then one quiet frame for stray bytes
	task automatic expect_text();
		int limit;
		int waited;
		limit  = (exp_q.size() + 2) * frame_cycles;
		waited = 0;
		while (rx_q.size() < exp_q.size() && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (rx_q.size() < exp_q.size())
			report_problem($sformatf("no complete answer from the DUT, got %0d of %0d bytes",
				rx_q.size(), exp_q.size()));
		repeat (frame_cycles) @(negedge clk);
		if (rx_q.size() != exp_q.size())
			report_value("byte count", 8'(exp_q.size()), 8'(rx_q.size()));
		for (int i = 0; i < exp_q.size() && i < rx_q.size(); i++) begin
			if (rx_q[i] !== exp_q[i])
				report_value($sformatf("byte %0d", i), exp_q[i], rx_q[i]);
		end
	endtask

	task automatic expect_silence();
		repeat (frame_cycles) @(negedge clk);
		if (tx_starts != starts_mark)
			report_value("frames sent", 8'd0, 8'(tx_starts - starts_mark));
	endtask

	// ====================
	// stimulus
	// ====================
	initial begin : stimulus
		int m, n;
		logic [7:0] bad;
		void'($urandom(49));
		rst_n = 1'b0;
		command = 8'd0;
		btn_confirm = 1'b0;
		btn_exit = 1'b0;
		uart_rxd = 1'b1;                                 // idle line
		tx_starts = 0;
		errors = 0;
		tests = 0;
		failed_tests = 0;
		wr_slot = 0;
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		repeat (2) @(negedge clk);

		begin_test("mode");
		if (uart_txd !== 1'b1) report_value("uart_txd", 8'd1, 8'(uart_txd));
		if (led !== 8'h00) report_value("led after reset", 8'h00, led);
		if (ld2 !== 8'h00) report_value("ld2 after reset", 8'h00, ld2);
		enter_mode(1);
		if (led !== 8'h01) report_value("led input", 8'h01, led);
		enter_mode(2);
		if (led !== 8'h02) report_value("led display", 8'h02, led);
		press(1'b1);
		if (led !== 8'h00) report_value("led exit", 8'h00, led);
		enter_mode(2);
		enter_mode(5);                                   // unknown code parks in idle
		if (led !== 8'h00) report_value("led code 5", 8'h00, led);
		end_test();

		begin_test("empty");
		enter_mode(2);
		for (int s = 0; s < matrix_pkg::slots; s++) begin
			model_text(0, 0);
			start_capture();
			send_byte(matrix_pkg::asc_zero + 8'(s));
			expect_text();
		end
		press(1'b1);
		end_test();

		begin_test("echo");
		enter_mode(1);
		repeat (n_echo) begin
			make_matrix(m, n);
			model_text(m, n);
			start_capture();
			send_matrix(m, n);
			if (ld2[0] !== 1'b1) report_value("ld2[0]", 8'd1, 8'(ld2[0])); // store flash
			store_model(m, n);
			expect_text();
		end
		end_test();

		begin_test("parse_error");
		bad = (rand_range(0, 4) == 0) ? matrix_pkg::asc_zero : 8'h35 + 8'(rand_range(1, 4));
		start_capture();
		if (rand_range(0, 1) == 1)
			send_byte(matrix_pkg::asc_zero + 8'(rand_range(1, matrix_pkg::max_dim))); // bad n
		send_byte(bad);
		if (ld2[1] !== 1'b1) report_value("ld2[1]", 8'd1, 8'(ld2[1]));
		expect_silence();
		make_matrix(m, n);                               // parser must recover
		model_text(m, n);
		start_capture();
		send_matrix(m, n);
		store_model(m, n);
		expect_text();
		press(1'b1);
		end_test();

		begin_test("round_robin");
		enter_mode(2);
		for (int s = 0; s < matrix_pkg::slots; s++) begin
			slot_text(s);
			start_capture();
			send_byte(matrix_pkg::asc_zero + 8'(s));
			expect_text();
		end
		press(1'b1);
		end_test();

		begin_test("idle");
		if (led !== 8'h00) report_value("led idle", 8'h00, led);
		start_capture();
		repeat (4) send_byte(matrix_pkg::asc_zero + 8'(rand_range(0, 9)));
		expect_silence();
		end_test();

		$display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* build.f */
common/matrix_pkg.sv
src/btn_debouncer.sv
uart/uart_rx.sv
uart/uart_tx.sv
src/mode_controller.sv
matrix/matrix_parser.sv
matrix/matrix_store.sv
matrix/matrix_printer.sv
src/sys_top.sv
verification/tb_sys_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the matrix terminal testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f build.f --top-module tb_sys_top -o tb_sys_top

out=$(./obj_dir/tb_sys_top)
echo "$out"

# status comes from the pass line only
echo "$out" | grep -q "^Simulation passed$"
